/* tracerPkg.sv */
package tracerPkg;

  // Every distance, position and direction is Q12.12
  localparam int fracBits = 12;
  localparam int fixedW = 24;

  // Signed fixed-point value for positions, directions and distances
  typedef logic signed [fixedW-1:0] fixed_t;

  // Track distances are compared unsigned so that a huge step distance
  // which wraps past the sign bit still reads as a far distance
  typedef logic [fixedW-1:0] ufixed_t;

  // Integer part of a map position
  typedef logic [fixedW-fracBits-1:0] mapCoord_t;

  // Wall ID from the map ROM, zero is an empty cell
  typedef logic [1:0] wallId_t;

  // Wall half-size in screen lines
  typedef logic [10:0] size_t;

  // Texture column inside one wall cell
  typedef logic [5:0] texU_t;

  // Hits closer than one eighth of a cell would overflow the texture scaler
  localparam fixed_t minDist = fixed_t'(1 << (fracBits - 3));

  // The first traced line sits 272 plane units before the screen centre
  localparam int addendStart = 272;

  // The deflection accumulates a whole plane per line and is scaled back by this shift
  localparam int addendShift = 8;

  // Per-line sequencer states
  typedef enum logic [2:0] {
    SdxPrep,
    SdyPrep,
    TracePrepX,
    TracePrepY,
    TraceStep,
    SizePrep,
    CalcTexU,
    TraceDone
  } seqState_t;

endpackage

/* rayDirection.sv */
module rayDirection (
  input  logic              clk,
  input  logic              do_reset,
  input  logic              i_frameLoad,
  input  logic              i_lineAdvance,
  input  tracerPkg::fixed_t i_facingX,
  input  tracerPkg::fixed_t i_facingY,
  input  tracerPkg::fixed_t i_vplaneX,
  input  tracerPkg::fixed_t i_vplaneY,
  output tracerPkg::fixed_t o_rayDirX,
  output tracerPkg::fixed_t o_rayDirY,
  output logic              o_rayIncX,
  output logic              o_rayIncY
);
  import tracerPkg::*;

  // Deflection from the facing vector, kept at full precision
  // and only scaled down when the direction is formed
  fixed_t addendX;
  fixed_t addendY;

  always_ff @(posedge clk) begin
    if (do_reset || i_frameLoad) begin
      // Start of frame puts the ray addendStart planes to one side
      // The product wraps to the fixed-point width on purpose
      addendX <= fixed_t'(-(i_vplaneX * addendStart));
      addendY <= fixed_t'(-(i_vplaneY * addendStart));
    end else if (i_lineAdvance) begin
      // One whole plane per line, wrapping like the rest of the arithmetic
      addendX <= addendX + i_vplaneX;
      addendY <= addendY + i_vplaneY;
    end
  end

  // The arithmetic shift scales the accumulated deflection back
  // to the size of a normal direction component
  // A larger shift here narrows the field of view
  assign o_rayDirX = i_facingX + (addendX >>> addendShift);
  assign o_rayDirY = i_facingY + (addendY >>> addendShift);

  // Walk direction per axis, zero counts as decreasing
  assign o_rayIncX = o_rayDirX > 0;
  assign o_rayIncY = o_rayDirY > 0;

endmodule

/* reciprocalDivider.sv */
module reciprocalDivider (
  input  logic              clk,
  input  logic              do_reset,
  input  logic              i_start,
  input  tracerPkg::fixed_t i_data,
  output tracerPkg::fixed_t o_data,
  output logic              o_done
);
  import tracerPkg::*;

  // One quotient bit per cycle over a dividend of fixedW+1 bits
  localparam int idxW = $clog2(fixedW + 1);
  localparam fixed_t maxPos = {1'b0, {(fixedW - 1){1'b1}}};

  logic              busy;
  logic [idxW-1:0]   bitIdx;
  ufixed_t           divisor;
  ufixed_t           rem;
  logic [fixedW:0]   quot;
  logic [fixedW:0]   trial;
  logic [fixedW:0]   diff;
  logic              dividendBit;
  logic              fits;

  // The dividend is 2^(2*fracBits), so only its top bit is set
  assign dividendBit = (bitIdx == idxW'(fixedW));
  assign trial = {rem, dividendBit};
  assign diff = trial - {1'b0, divisor};
  // A zero divisor always fits, which fills the quotient with ones
  assign fits = trial >= {1'b0, divisor};

  always_ff @(posedge clk) begin
    if (do_reset) begin
      busy <= 1'b0;
      bitIdx <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
        bitIdx <= idxW'(fixedW);
      end else if (busy) begin
        bitIdx <= bitIdx - 1'b1;
        // Last quotient bit is written at this edge
        if (bitIdx == '0) begin
          busy <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      // Magnitude only; the most negative input still fits unsigned
      divisor <= (i_data < 0) ? ufixed_t'(-i_data) : ufixed_t'(i_data);
      rem <= '0;
      quot <= '0;
    end else if (busy) begin
      rem <= fits ? diff[fixedW-1:0] : trial[fixedW-1:0];
      quot <= {quot[fixedW-1:0], fits};
    end
  end

  // Anything at or above 2^(fixedW-1) saturates, which also covers a zero input
  assign o_data = (quot[fixedW:fixedW-1] != 2'b00) ? maxPos : fixed_t'(quot[fixedW-1:0]);

  // The sequencer shares this unit three times a line and must wait for each result
  startWhileBusy: assert property (@(posedge clk) disable iff (do_reset) i_start |-> !busy)
    else $error("Reciprocal started while a division is still running");

endmodule

/* ddaWalker.sv */
module ddaWalker #(
  parameter int mapWBits = 4,
  parameter int mapHBits = 4
) (
  input  logic                 clk,
  input  logic                 do_reset,
  input  logic                 i_seedX,
  input  logic                 i_seedY,
  input  logic                 i_step,
  input  tracerPkg::fixed_t    i_seedValue,
  input  tracerPkg::fixed_t    i_stepDistX,
  input  tracerPkg::fixed_t    i_stepDistY,
  input  tracerPkg::fixed_t    i_playerX,
  input  tracerPkg::fixed_t    i_playerY,
  input  logic                 i_rayIncX,
  input  logic                 i_rayIncY,
  output tracerPkg::mapCoord_t o_mapX,
  output tracerPkg::mapCoord_t o_mapY,
  output logic [mapWBits-1:0]  o_mapCol,
  output logic [mapHBits-1:0]  o_mapRow,
  output logic                 o_side,
  output tracerPkg::fixed_t    o_hitDist
);
  import tracerPkg::*;

  // Distance along the ray to the next X and Y gridline crossing
  ufixed_t trackX;
  ufixed_t trackY;
  mapCoord_t playerMapX;
  mapCoord_t playerMapY;
  logic stepOnX;

  assign playerMapX = i_playerX[fixedW-1:fracBits];
  assign playerMapY = i_playerY[fixedW-1:fracBits];

  // Whichever gridline is nearer gets crossed first
  assign stepOnX = trackX < trackY;

  always_ff @(posedge clk) begin
    if (do_reset) begin
      o_mapX <= '0;
      o_mapY <= '0;
      o_side <= 1'b0;
    end else if (i_seedX) begin
      o_mapX <= playerMapX;
    end else if (i_seedY) begin
      o_mapY <= playerMapY;
    end else if (i_step) begin
      if (stepOnX) begin
        o_mapX <= i_rayIncX ? o_mapX + 1'b1 : o_mapX - 1'b1;
        o_side <= 1'b0;
      end else begin
        o_mapY <= i_rayIncY ? o_mapY + 1'b1 : o_mapY - 1'b1;
        o_side <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_seedX) begin
      trackX <= ufixed_t'(i_seedValue);
      // No gridline crossed yet on this line
      o_hitDist <= '0;
    end else if (i_seedY) begin
      trackY <= ufixed_t'(i_seedValue);
    end else if (i_step) begin
      // The crossing just taken becomes the distance to the cell entered
      if (stepOnX) begin
        o_hitDist <= fixed_t'(trackX);
        trackX <= trackX + ufixed_t'(i_stepDistX);
      end else begin
        o_hitDist <= fixed_t'(trackY);
        trackY <= trackY + ufixed_t'(i_stepDistY);
      end
    end
  end

  // Map ROM address is the low bits of the current cell
  assign o_mapCol = o_mapX[mapWBits-1:0];
  assign o_mapRow = o_mapY[mapHBits-1:0];

  // The sequencer must finish seeding both tracks before walking
  seedBeforeStep: assert property (@(posedge clk) disable iff (do_reset)
    i_step |-> !(i_seedX || i_seedY))
    else $error("Map step coincides with a track seed");

endmodule

/* traceSequencer.sv */
module traceSequencer (
  input  logic                 clk,
  input  logic                 do_reset,
  input  logic                 i_vsync,
  input  logic                 i_hmax,
  input  tracerPkg::fixed_t    i_playerX,
  input  tracerPkg::fixed_t    i_playerY,
  input  tracerPkg::fixed_t    i_rayDirX,
  input  tracerPkg::fixed_t    i_rayDirY,
  input  logic                 i_rayIncX,
  input  logic                 i_rayIncY,
  input  tracerPkg::fixed_t    i_rcpData,
  input  logic                 i_rcpDone,
  output logic                 o_rcpStart,
  output tracerPkg::fixed_t    o_rcpData,
  output logic                 o_frameLoad,
  output logic                 o_lineAdvance,
  output logic                 o_seedX,
  output logic                 o_seedY,
  output logic                 o_step,
  output tracerPkg::fixed_t    o_seedValue,
  output tracerPkg::fixed_t    o_stepDistX,
  output tracerPkg::fixed_t    o_stepDistY,
  input  tracerPkg::mapCoord_t i_mapX,
  input  tracerPkg::mapCoord_t i_mapY,
  input  logic                 i_side,
  input  tracerPkg::fixed_t    i_hitDist,
  input  tracerPkg::wallId_t   i_mapVal,
  output logic                 o_ready,
  output tracerPkg::wallId_t   o_wall,
  output logic                 o_side,
  output tracerPkg::size_t     o_size,
  output tracerPkg::texU_t     o_texU,
  output tracerPkg::fixed_t    o_texA
);
  import tracerPkg::*;

  localparam fixed_t fixedOne = fixed_t'(1 << fracBits);

  seqState_t state;
  // Second track is seeded in the first TraceStep cycle, when its product lands
  logic seedYPending;
  logic frameRestart;
  logic hmaxAccept;
  logic wallHit;

  fixed_t stepDistX;
  fixed_t stepDistY;
  wallId_t wall;
  size_t sizeReg;
  texU_t texU;

  fixed_t fracX;
  fixed_t fracY;
  fixed_t partialX;
  fixed_t partialY;
  fixed_t mulA;
  fixed_t mulB;
  logic signed [2*fixedW-1:0] mulFull;
  fixed_t mulProd;
  fixed_t wallPartial;
  logic texMirror;

  assign frameRestart = do_reset || i_vsync;
  assign hmaxAccept = (state == TraceDone) && i_hmax;

  // Ray control strobes
  assign o_frameLoad = i_vsync;
  assign o_lineAdvance = hmaxAccept;
  assign o_ready = (state == TraceDone);

  // Distance from the player to the first gridline on each axis, in cells
  assign fracX = {{(fixedW - fracBits){1'b0}}, i_playerX[fracBits-1:0]};
  assign fracY = {{(fixedW - fracBits){1'b0}}, i_playerY[fracBits-1:0]};
  assign partialX = i_rayIncX ? fixedOne - fracX : fracX;
  assign partialY = i_rayIncY ? fixedOne - fracY : fracY;

  // Shared multiplier inputs follow the state that selects them;
  // the registered product is read one cycle later
  always_comb begin
    case (state)
      TracePrepX: begin
        mulA = stepDistX;
        mulB = partialX;
      end
      TracePrepY: begin
        mulA = stepDistY;
        mulB = partialY;
      end
      default: begin
        // Hit point along the wall uses the ray component across the wall
        mulA = i_side ? i_rayDirX : i_rayDirY;
        mulB = i_hitDist;
      end
    endcase
  end

  assign mulFull = mulA * mulB;

  always_ff @(posedge clk) begin
    mulProd <= fixed_t'(mulFull >>> fracBits);
  end

  // Reciprocal source and start strobe, one user per phase of the line
  assign o_rcpData = (state == SizePrep) ? i_hitDist :
                     (state == SdxPrep)  ? i_rayDirX : i_rayDirY;
  assign o_rcpStart = (state == SdxPrep) || (state == SizePrep) ||
                      ((state == SdyPrep) && i_rcpDone);

  // Walker controls
  assign o_seedValue = mulProd;
  assign o_stepDistX = stepDistX;
  assign o_stepDistY = stepDistY;
  assign o_seedX = (state == TracePrepY);
  assign o_seedY = (state == TraceStep) && seedYPending;

  // A hit needs a wall cell that is not the player's own and is far enough away
  assign wallHit = (i_hitDist >= minDist) && (i_mapVal != '0) &&
                   !((i_mapX == i_playerX[fixedW-1:fracBits]) &&
                     (i_mapY == i_playerY[fixedW-1:fracBits]));
  assign o_step = (state == TraceStep) && !seedYPending && !wallHit;

  // Texture column is the fraction of the hit point along the wall face
  assign wallPartial = mulProd + (i_side ? i_playerX : i_playerY);
  assign texMirror = i_side ? i_rayIncY : !i_rayIncX;

  always_ff @(posedge clk) begin
    if (frameRestart) begin
      state <= SdxPrep;
      seedYPending <= 1'b0;
      o_wall <= '0;
      o_side <= 1'b0;
      o_size <= '0;
      o_texU <= '0;
      o_texA <= '0;
    end else begin
      case (state)
        SdxPrep: state <= SdyPrep;
        SdyPrep: if (i_rcpDone) state <= TracePrepX;
        TracePrepX: if (i_rcpDone) state <= TracePrepY;
        TracePrepY: begin
          seedYPending <= 1'b1;
          state <= TraceStep;
        end
        TraceStep: begin
          if (seedYPending) begin
            seedYPending <= 1'b0;
          end else if (wallHit) begin
            state <= SizePrep;
          end
        end
        SizePrep: state <= CalcTexU;
        CalcTexU: if (i_rcpDone) state <= TraceDone;
        TraceDone: begin
          // Present the finished line and start the next ray
          if (hmaxAccept) begin
            o_wall <= wall;
            o_side <= i_side;
            o_size <= sizeReg;
            o_texU <= texU;
            o_texA <= i_hitDist;
            state <= SdxPrep;
          end
        end
        default: state <= SdxPrep;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SdyPrep && i_rcpDone) begin
      stepDistX <= i_rcpData;
    end
    if (state == TracePrepX && i_rcpDone) begin
      stepDistY <= i_rcpData;
    end
    if (state == TraceStep && !seedYPending && wallHit) begin
      wall <= i_mapVal;
    end
    if (state == CalcTexU && i_rcpDone) begin
      // 256 / distance, clipped to 11 bits
      sizeReg <= i_rcpData[fracBits+2 -: $bits(size_t)];
      texU <= wallPartial[fracBits-1 -: $bits(texU_t)] ^ {$bits(texU_t){texMirror}};
    end
  end

  // State must stay known and legal between frame restarts
  legalState: assert property (@(posedge clk) disable iff (do_reset)
    !$isunknown(state) && (state inside {SdxPrep, SdyPrep, TracePrepX, TracePrepY,
                                         TraceStep, SizePrep, CalcTexU, TraceDone}))
    else $error("Sequencer left its legal states");

endmodule

/* wallTracer.sv */
module wallTracer #(
  parameter int mapWBits = 4,
  parameter int mapHBits = 4
) (
  input  logic                clk,
  input  logic                do_reset,
  input  logic                i_vsync,
  input  logic                i_hmax,
  input  tracerPkg::fixed_t   i_playerX,
  input  tracerPkg::fixed_t   i_playerY,
  input  tracerPkg::fixed_t   i_facingX,
  input  tracerPkg::fixed_t   i_facingY,
  input  tracerPkg::fixed_t   i_vplaneX,
  input  tracerPkg::fixed_t   i_vplaneY,
  output logic [mapWBits-1:0] o_mapCol,
  output logic [mapHBits-1:0] o_mapRow,
  input  tracerPkg::wallId_t  i_mapVal,
  output logic                o_ready,
  output tracerPkg::wallId_t  o_wall,
  output logic                o_side,
  output tracerPkg::size_t    o_size,
  output tracerPkg::texU_t    o_texU,
  output tracerPkg::fixed_t   o_texA
);
  import tracerPkg::*;

  // Ray direction
  fixed_t rayDirX;
  fixed_t rayDirY;
  logic rayIncX;
  logic rayIncY;
  logic frameLoad;
  logic lineAdvance;

  // Shared reciprocal
  logic rcpStart;
  logic rcpDone;
  fixed_t rcpIn;
  fixed_t rcpOut;
  // A frame restart abandons any division still in flight
  logic rcpReset;

  // Map walk
  logic seedX;
  logic seedY;
  logic step;
  fixed_t seedValue;
  fixed_t stepDistX;
  fixed_t stepDistY;
  mapCoord_t mapX;
  mapCoord_t mapY;
  logic walkSide;
  fixed_t hitDist;

  assign rcpReset = do_reset || i_vsync;

  rayDirection rayDirection_i (
    .clk          (clk),
    .do_reset     (do_reset),
    .i_frameLoad  (frameLoad),
    .i_lineAdvance(lineAdvance),
    .i_facingX    (i_facingX),
    .i_facingY    (i_facingY),
    .i_vplaneX    (i_vplaneX),
    .i_vplaneY    (i_vplaneY),
    .o_rayDirX    (rayDirX),
    .o_rayDirY    (rayDirY),
    .o_rayIncX    (rayIncX),
    .o_rayIncY    (rayIncY)
  );

  reciprocalDivider reciprocalDivider_i (
    .clk     (clk),
    .do_reset(rcpReset),
    .i_start (rcpStart),
    .i_data  (rcpIn),
    .o_data  (rcpOut),
    .o_done  (rcpDone)
  );

  ddaWalker #(
    .mapWBits(mapWBits),
    .mapHBits(mapHBits)
  ) ddaWalker_i (
    .clk        (clk),
    .do_reset   (do_reset),
    .i_seedX    (seedX),
    .i_seedY    (seedY),
    .i_step     (step),
    .i_seedValue(seedValue),
    .i_stepDistX(stepDistX),
    .i_stepDistY(stepDistY),
    .i_playerX  (i_playerX),
    .i_playerY  (i_playerY),
    .i_rayIncX  (rayIncX),
    .i_rayIncY  (rayIncY),
    .o_mapX     (mapX),
    .o_mapY     (mapY),
    .o_mapCol   (o_mapCol),
    .o_mapRow   (o_mapRow),
    .o_side     (walkSide),
    .o_hitDist  (hitDist)
  );

  traceSequencer traceSequencer_i (
    .clk          (clk),
    .do_reset     (do_reset),
    .i_vsync      (i_vsync),
    .i_hmax       (i_hmax),
    .i_playerX    (i_playerX),
    .i_playerY    (i_playerY),
    .i_rayDirX    (rayDirX),
    .i_rayDirY    (rayDirY),
    .i_rayIncX    (rayIncX),
    .i_rayIncY    (rayIncY),
    .i_rcpData    (rcpOut),
    .i_rcpDone    (rcpDone),
    .o_rcpStart   (rcpStart),
    .o_rcpData    (rcpIn),
    .o_frameLoad  (frameLoad),
    .o_lineAdvance(lineAdvance),
    .o_seedX      (seedX),
    .o_seedY      (seedY),
    .o_step       (step),
    .o_seedValue  (seedValue),
    .o_stepDistX  (stepDistX),
    .o_stepDistY  (stepDistY),
    .i_mapX       (mapX),
    .i_mapY       (mapY),
    .i_side       (walkSide),
    .i_hitDist    (hitDist),
    .i_mapVal     (i_mapVal),
    .o_ready      (o_ready),
    .o_wall       (o_wall),
    .o_side       (o_side),
    .o_size       (o_size),
    .o_texU       (o_texU),
    .o_texA       (o_texA)
  );

endmodule

/* tbClock.sv */
module tbClock #(
  parameter int period = 100,
  parameter int resetCycles = 5
) (
  output logic clk,
  output logic do_reset
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Reset covers the first rising edges and is released on a falling edge
  initial begin
    do_reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    do_reset = 1'b0;
  end

endmodule

/* tbChecker.sv */
module tbChecker (
  input  logic               clk,
  input  logic               do_reset,
  input  logic               i_vsync,
  input  logic               i_hmax,
  input  tracerPkg::fixed_t  i_playerX,
  input  tracerPkg::fixed_t  i_playerY,
  input  tracerPkg::fixed_t  i_facingX,
  input  tracerPkg::fixed_t  i_facingY,
  input  tracerPkg::fixed_t  i_vplaneX,
  input  tracerPkg::fixed_t  i_vplaneY,
  input  logic [511:0]       i_mapBits,
  input  logic [3:0]         i_mapCol,
  input  logic [3:0]         i_mapRow,
  input  logic               i_ready,
  input  tracerPkg::wallId_t i_wall,
  input  logic               i_side,
  input  tracerPkg::size_t   i_size,
  input  tracerPkg::texU_t   i_texU,
  input  tracerPkg::fixed_t  i_texA,
  output int                 o_errorCount
);
  import tracerPkg::*;

  localparam fixed_t maxPositive = 24'h7f_ffff;
  localparam fixed_t oneEighth = 24'd512;

  int errorCount;
  int linesChecked;
  int lineInFrame;
  fixed_t addendX;
  fixed_t addendY;
  logic checkZero;
  logic checkLine;
  logic checkHold;

  // Expected results of the line just accepted
  wallId_t expWall;
  logic expSide;
  size_t expSize;
  texU_t expTexU;
  fixed_t expTexA;
  // Map cell of the hit, which the walker still addresses while the line is shown
  logic [3:0] expMapCol;
  logic [3:0] expMapRow;

  // Outputs seen at the previous falling edge
  wallId_t heldWall;
  logic heldSide;
  size_t heldSize;
  texU_t heldTexU;
  fixed_t heldTexA;

  logic sawSide0;
  logic sawSide1;
  logic sawMirrorX;
  logic sawMirrorY;

  assign o_errorCount = errorCount;

  initial begin
    errorCount = 0;
    linesChecked = 0;
    lineInFrame = 0;
    checkZero = 1'b0;
    checkLine = 1'b0;
    checkHold = 1'b0;
    sawSide0 = 1'b0;
    sawSide1 = 1'b0;
    sawMirrorX = 1'b0;
    sawMirrorY = 1'b0;
  end

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
    $display("Mismatch %s: got 0x%0h expected 0x%0h (frame line %0d)",
             name, got, expected, lineInFrame);
    errorCount++;
  endtask

  task automatic reportFailure(input string what);
    $display("Failure: %s", what);
    errorCount++;
  endtask

  // floor(2^24 / |a|), clipped to the largest positive value
  function automatic fixed_t reciprocal(input fixed_t a);
    logic [63:0] magnitude;
    logic [63:0] quotient;
    magnitude = (a < 0) ? 64'(-int'(a)) : 64'(int'(a));
    if (magnitude == 0) begin
      return maxPositive;
    end
    quotient = (64'd1 << 24) / magnitude;
    if (quotient >= (64'd1 << 23)) begin
      return maxPositive;
    end
    return fixed_t'(quotient);
  endfunction

  // Q12.12 product, truncated back to 24 bits
  function automatic fixed_t mulFixed(input fixed_t a, input fixed_t b);
    logic signed [47:0] full;
    full = a * b;
    return full[35:12];
  endfunction

  function automatic wallId_t mapAt(input logic [11:0] x, input logic [11:0] y);
    int index;
    index = int'(y[3:0]) * 16 + int'(x[3:0]);
    return i_mapBits[index*2 +: 2];
  endfunction

  // Traces one ray through the map and fills the expected results
  task automatic modelLine();
    fixed_t rayX;
    fixed_t rayY;
    fixed_t stepX;
    fixed_t stepY;
    fixed_t partX;
    fixed_t partY;
    fixed_t hitDist;
    fixed_t wallPos;
    fixed_t sizeRcp;
    ufixed_t trackX;
    ufixed_t trackY;
    logic [11:0] mapX;
    logic [11:0] mapY;
    logic incX;
    logic incY;
    logic side;
    logic hit;
    logic mirror;
    int steps;
    rayX = i_facingX + (addendX >>> 8);
    rayY = i_facingY + (addendY >>> 8);
    incX = rayX > 0;
    incY = rayY > 0;
    stepX = reciprocal(rayX);
    stepY = reciprocal(rayY);
    // Part of the player's cell left before the first gridline
    partX = incX ? 24'd4096 - {12'd0, i_playerX[11:0]} : {12'd0, i_playerX[11:0]};
    partY = incY ? 24'd4096 - {12'd0, i_playerY[11:0]} : {12'd0, i_playerY[11:0]};
    trackX = mulFixed(stepX, partX);
    trackY = mulFixed(stepY, partY);
    mapX = i_playerX[23:12];
    mapY = i_playerY[23:12];
    hitDist = '0;
    side = 1'b0;
    hit = 1'b0;
    steps = 0;
    while (!hit && steps < 10000) begin
      if (hitDist >= oneEighth && mapAt(mapX, mapY) != 0 &&
          !(mapX == i_playerX[23:12] && mapY == i_playerY[23:12])) begin
        hit = 1'b1;
      end else begin
        // Nearer gridline first, ties go to Y
        if (trackX < trackY) begin
          hitDist = trackX;
          trackX = trackX + stepX;
          mapX = incX ? mapX + 1 : mapX - 1;
          side = 1'b0;
        end else begin
          hitDist = trackY;
          trackY = trackY + stepY;
          mapY = incY ? mapY + 1 : mapY - 1;
          side = 1'b1;
        end
        steps++;
      end
    end
    if (!hit) begin
      reportFailure("reference ray never reached a wall");
    end
    expWall = mapAt(mapX, mapY);
    expSide = side;
    expTexA = hitDist;
    expMapCol = mapX[3:0];
    expMapRow = mapY[3:0];
    sizeRcp = reciprocal(hitDist);
    expSize = sizeRcp[14:4];
    // Hit point along the wall face, using the ray component across the wall
    wallPos = mulFixed(side ? rayX : rayY, hitDist) + (side ? i_playerX : i_playerY);
    mirror = side ? incY : !incX;
    expTexU = wallPos[11:6] ^ {6{mirror}};
    if (side) sawSide1 = 1'b1;
    else sawSide0 = 1'b1;
    if (side && mirror) sawMirrorY = 1'b1;
    if (!side && mirror) sawMirrorX = 1'b1;
  endtask

  // Inputs and pre-edge DUT state are sampled at the rising edge
  always @(posedge clk) begin
    checkZero = 1'b0;
    checkLine = 1'b0;
    checkHold = 1'b0;
    if (do_reset || i_vsync) begin
      addendX = fixed_t'(-(int'(i_vplaneX) * 272));
      addendY = fixed_t'(-(int'(i_vplaneY) * 272));
      lineInFrame = 0;
      checkZero = 1'b1;
    end else if (i_ready && i_hmax) begin
      modelLine();
      addendX = addendX + i_vplaneX;
      addendY = addendY + i_vplaneY;
      checkLine = 1'b1;
      linesChecked++;
    end else begin
      checkHold = 1'b1;
    end
  end

  // Registered outputs have settled by the falling edge
  always @(negedge clk) begin
    if (checkZero) begin
      if (i_ready) reportFailure("o_ready high during a frame restart");
      if (i_wall != 0) reportMismatch("o_wall", 32'(i_wall), 0);
      if (i_side != 0) reportMismatch("o_side", 32'(i_side), 0);
      if (i_size != 0) reportMismatch("o_size", 32'(i_size), 0);
      if (i_texU != 0) reportMismatch("o_texU", 32'(i_texU), 0);
      if (i_texA != 0) reportMismatch("o_texA", 32'(i_texA), 0);
    end
    if (checkLine) begin
      if (i_wall != expWall) reportMismatch("o_wall", 32'(i_wall), 32'(expWall));
      if (i_side != expSide) reportMismatch("o_side", 32'(i_side), 32'(expSide));
      if (i_size != expSize) reportMismatch("o_size", 32'(i_size), 32'(expSize));
      if (i_texU != expTexU) reportMismatch("o_texU", 32'(i_texU), 32'(expTexU));
      if (i_texA != expTexA) reportMismatch("o_texA", 32'(i_texA), 32'(expTexA));
      // The walker has not been reseeded yet, so the map address is the hit cell
      if (i_mapCol != expMapCol) begin
        reportMismatch("o_mapCol", 32'(i_mapCol), 32'(expMapCol));
      end
      if (i_mapRow != expMapRow) begin
        reportMismatch("o_mapRow", 32'(i_mapRow), 32'(expMapRow));
      end
      lineInFrame++;
    end
    // Without an accepted strobe the results must not move
    if (checkHold) begin
      if (i_wall != heldWall) reportMismatch("o_wall", 32'(i_wall), 32'(heldWall));
      if (i_side != heldSide) reportMismatch("o_side", 32'(i_side), 32'(heldSide));
      if (i_size != heldSize) reportMismatch("o_size", 32'(i_size), 32'(heldSize));
      if (i_texU != heldTexU) reportMismatch("o_texU", 32'(i_texU), 32'(heldTexU));
      if (i_texA != heldTexA) reportMismatch("o_texA", 32'(i_texA), 32'(heldTexA));
    end
    heldWall = i_wall;
    heldSide = i_side;
    heldSize = i_size;
    heldTexU = i_texU;
    heldTexA = i_texA;
  end

  task automatic finalCheck(input int expectedLines);
    if (linesChecked != expectedLines) begin
      $display("Failure: %0d lines presented, %0d expected", linesChecked, expectedLines);
      errorCount++;
    end
    if (!sawSide0) reportFailure("no line hit an X-side wall");
    if (!sawSide1) reportFailure("no line hit a Y-side wall");
    if (!sawMirrorX) reportFailure("no mirrored texture column on an X-side wall");
    if (!sawMirrorY) reportFailure("no mirrored texture column on a Y-side wall");
  endtask

endmodule

/* tbWallTracer.sv */
module tbWallTracer;
  import tracerPkg::*;

  localparam int frames = 6;
  localparam int linesPerFrame = 40;
  // Three divisions, two multiplier passes and some slack per line
  localparam int timeoutCycles = frames * linesPerFrame * (3 * (fixedW + 3) + 2 * 32 + 20);

  logic clk;
  logic do_reset;
  logic vsync;
  logic hmax;
  fixed_t playerX;
  fixed_t playerY;
  fixed_t facingX;
  fixed_t facingY;
  fixed_t vplaneX;
  fixed_t vplaneY;
  logic [3:0] mapCol;
  logic [3:0] mapRow;
  wallId_t mapVal;
  logic ready;
  wallId_t wall;
  logic side;
  size_t size;
  texU_t texU;
  fixed_t texA;

  logic [511:0] mapBits;
  logic [31:0] lcgState;
  int cycleCount;
  int errorCount;

  tbClock #(.period(100), .resetCycles(5)) clkGen_i (
    .clk     (clk),
    .do_reset(do_reset)
  );

  wallTracer #(.mapWBits(4), .mapHBits(4)) dut_i (
    .clk      (clk),
    .do_reset (do_reset),
    .i_vsync  (vsync),
    .i_hmax   (hmax),
    .i_playerX(playerX),
    .i_playerY(playerY),
    .i_facingX(facingX),
    .i_facingY(facingY),
    .i_vplaneX(vplaneX),
    .i_vplaneY(vplaneY),
    .o_mapCol (mapCol),
    .o_mapRow (mapRow),
    .i_mapVal (mapVal),
    .o_ready  (ready),
    .o_wall   (wall),
    .o_side   (side),
    .o_size   (size),
    .o_texU   (texU),
    .o_texA   (texA)
  );

  tbChecker chk_i (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_vsync     (vsync),
    .i_hmax      (hmax),
    .i_playerX   (playerX),
    .i_playerY   (playerY),
    .i_facingX   (facingX),
    .i_facingY   (facingY),
    .i_vplaneX   (vplaneX),
    .i_vplaneY   (vplaneY),
    .i_mapBits   (mapBits),
    .i_mapCol    (mapCol),
    .i_mapRow    (mapRow),
    .i_ready     (ready),
    .i_wall      (wall),
    .i_side      (side),
    .i_size      (size),
    .i_texU      (texU),
    .i_texA      (texA),
    .o_errorCount(errorCount)
  );

  // Map ROM answers in the same cycle
  assign mapVal = mapBits[(int'(mapRow) * 16 + int'(mapCol)) * 2 +: 2];

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState >> 8;
  endfunction

  function automatic fixed_t randomSigned(input int span);
    int offset;
    offset = int'(nextRandom() % (2 * span + 1));
    return fixed_t'(offset - span);
  endfunction

  // Border walls all round, about a quarter of the interior filled
  task automatic buildMap();
    logic [31:0] r;
    for (int row = 0; row < 16; row++) begin
      for (int col = 0; col < 16; col++) begin
        r = nextRandom();
        if (row == 0 || row == 15 || col == 0 || col == 15) begin
          mapBits[(row * 16 + col) * 2 +: 2] = 2'd1;
        end else if (r % 4 == 0) begin
          mapBits[(row * 16 + col) * 2 +: 2] = 2'(1 + (r >> 4) % 3);
        end else begin
          mapBits[(row * 16 + col) * 2 +: 2] = 2'd0;
        end
      end
    end
  endtask

  task automatic startFrame();
    int cx;
    int cy;
    do begin
      cx = 1 + int'(nextRandom() % 14);
      cy = 1 + int'(nextRandom() % 14);
    end while (mapBits[(cy * 16 + cx) * 2 +: 2] != 0);
    playerX = {12'(cx), 12'(nextRandom())};
    playerY = {12'(cy), 12'(nextRandom())};
    facingX = randomSigned(4096);
    facingY = randomSigned(4096);
    vplaneX = randomSigned(2048);
    vplaneY = randomSigned(2048);
    vsync = 1'b1;
    repeat (3) @(negedge clk);
    vsync = 1'b0;
  endtask

  task automatic presentLine();
    int delay;
    // A stray strobe before the line is finished must be ignored
    if (nextRandom() % 5 == 0 && !ready) begin
      hmax = 1'b1;
      @(negedge clk);
      hmax = 1'b0;
    end
    while (!ready) @(negedge clk);
    delay = int'(nextRandom() % 16);
    repeat (delay) @(negedge clk);
    hmax = 1'b1;
    @(negedge clk);
    hmax = 1'b0;
  endtask

  initial begin
    lcgState = 32'hb363_954d;
    vsync = 1'b0;
    hmax = 1'b0;
    playerX = '0;
    playerY = '0;
    facingX = '0;
    facingY = '0;
    vplaneX = '0;
    vplaneY = '0;
    buildMap();
    @(negedge clk);
    while (do_reset) @(negedge clk);
    for (int frame = 0; frame < frames; frame++) begin
      startFrame();
      for (int line = 0; line < linesPerFrame; line++) begin
        presentLine();
      end
    end
    repeat (2) @(negedge clk);
    chk_i.finalCheck(frames * linesPerFrame);
    @(negedge clk);
    $display("Errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    cycleCount = 0;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("Errors: %0d", errorCount + 1);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

/* flist.f */
tracerPkg.sv
rayDirection.sv
reciprocalDivider.sv
ddaWalker.sv
traceSequencer.sv
wallTracer.sv
tbClock.sv
tbChecker.sv
tbWallTracer.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tbWallTracer -f flist.f -o simWallTracer

./obj_dir/simWallTracer | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
